// File: hdl/phase_macros.svh
`ifndef PHASE_MACROS_SVH
`define PHASE_MACROS_SVH

// phase target and counter width
`define PHASE_WIDTH 8

// phase restored by the default opcode
`define PHASE_DEFAULT 8'h00

// psclk cycles spent waiting for psdone before giving up
`define PS_DONE_TIMEOUT 64

// wide enough to count up to the done timeout
`define PS_CNT_WIDTH 7

// psclk cycles from reset release until the engine reports lock
`define PS_LOCK_CYCLES 16

`endif

// File: hdl/phase_pkg.sv
`include "phase_macros.svh"

package phase_pkg;

    // host opcodes
    typedef enum logic [1:0] {
        OP_SET_ABS  = 2'd0,  // value becomes the new target
        OP_STEP_REL = 2'd1,  // target plus value, wraps
        OP_DEFAULT  = 2'd2,  // back to default phase
        OP_CLEAR    = 2'd3   // drop sticky flags only
    } phase_op_e;

    // stepper fsm
    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,  // counter matches target
        ST_START     = 2'd1,  // compare and maybe issue psen
        ST_WAIT_DONE = 2'd2   // one step in flight
    } step_state_e;

    // accepted command, registered in the decoder
    typedef struct packed {
        logic [`PHASE_WIDTH-1:0] new_target;  // also the current target
        logic                    load;        // one cycle, start stepping
        logic                    clear;       // one cycle, clear flags
    } phase_cmd_t;

    // host visible status word
    typedef struct packed {
        logic [`PHASE_WIDTH-1:0] phase;         // confirmed counter
        logic                    ready;
        logic                    busy;
        logic                    cmd_rejected;  // sticky
        logic                    timeout;       // sticky
    } phase_status_t;

endpackage

// File: hdl/phase_cmd_decoder.sv
`timescale 1ns/1ps
`include "phase_macros.svh"

module phase_cmd_decoder
    import phase_pkg::*;
(
    input  logic                    psclk,
    input  logic                    rst,
    input  logic                    cmd_valid,  // single cycle strobe
    input  phase_op_e               cmd_op,
    input  logic [`PHASE_WIDTH-1:0] cmd_value,  // two's complement
    input  logic                    ready,      // from status block
    output phase_cmd_t              cmd,
    output logic                    rejected    // pulse, strobe while busy
);

    logic                    accept;       // strobe taken this cycle
    logic                    op_is_clear;
    logic [`PHASE_WIDTH-1:0] cur_target;   // last accepted target
    logic [`PHASE_WIDTH-1:0] rel_target;   // wrapping sum for relative steps
    logic [`PHASE_WIDTH-1:0] next_target;

    assign accept      = cmd_valid && ready;
    assign op_is_clear = (cmd_op == OP_CLEAR);

    // the registered command field doubles as the target register
    assign cur_target = cmd.new_target;

    // carry out dropped on purpose, phase wraps
    assign rel_target = cur_target + cmd_value;

    always_comb begin
        case (cmd_op)
            OP_SET_ABS:  next_target = cmd_value;        // absolute load
            OP_STEP_REL: next_target = rel_target;       // relative move
            OP_DEFAULT:  next_target = `PHASE_DEFAULT;   // home position
            OP_CLEAR:    next_target = cur_target;       // target untouched
            default:     next_target = cur_target;
        endcase
    end

    // command register, load and clear are one cycle wide
    always_ff @(posedge psclk or posedge rst) begin
        if (rst) begin
            cmd.new_target <= '0;  // counter also starts at 0
            cmd.load       <= 1'b0;
            cmd.clear      <= 1'b0;
        end else begin
            cmd.load  <= accept && !op_is_clear;  // only moves go to the stepper
            cmd.clear <= accept && op_is_clear;
            if (accept) begin
                cmd.new_target <= next_target;
            end
        end
    end

    // strobes while not ready are dropped, never queued
    always_ff @(posedge psclk or posedge rst) begin
        if (rst) begin
            rejected <= 1'b0;
        end else begin
            rejected <= cmd_valid && !ready;  // status makes it sticky
        end
    end

endmodule

// File: hdl/phase_stepper.sv
`timescale 1ns/1ps
`include "phase_macros.svh"

module phase_stepper
    import phase_pkg::*;
(
    input  logic                    psclk,
    input  logic                    rst,
    input  phase_cmd_t              cmd,        // from decoder
    input  logic                    psdone,     // engine step finished
    output logic                    psen,       // one cycle per step
    output logic                    psincdec,   // 1 = increment
    output logic [`PHASE_WIDTH-1:0] phase,      // confirmed phase counter
    output logic                    busy,
    output logic                    step_done,  // counter reached target
    output logic                    timeout     // psdone never came
);

    step_state_e                state;
    logic [`PHASE_WIDTH-1:0]    target;        // copy taken at load
    logic [`PHASE_WIDTH:0]      diff;          // one extra bit for the sign
    logic                       diff_nz;
    logic                       psdone_r;      // adds the second cycle after psdone
    logic                       last_inc;      // direction of the step in flight
    logic [`PS_CNT_WIDTH-1:0]   wait_cnt;      // cycles spent in ST_WAIT_DONE
    logic                       wait_expired;

    // both operands sign extended so the msb gives the direction
    assign diff    = {target[`PHASE_WIDTH-1], target} - {phase[`PHASE_WIDTH-1], phase};
    assign diff_nz = |diff;

    assign psen      = (state == ST_START) && diff_nz;  // only when there is distance left
    assign psincdec  = psen && !diff[`PHASE_WIDTH];     // valid with psen, low otherwise
    assign busy      = (state != ST_IDLE);
    assign step_done = (state == ST_START) && !diff_nz; // status turns this into settled

    assign wait_expired = (wait_cnt == `PS_CNT_WIDTH'(`PS_DONE_TIMEOUT - 1));
    assign timeout      = (state == ST_WAIT_DONE) && !psdone_r && wait_expired;

    // engine done pulse registered once
    always_ff @(posedge psclk or posedge rst) begin
        if (rst) begin
            psdone_r <= 1'b0;
        end else begin
            psdone_r <= psdone;
        end
    end

    // target captured only when idle, ready keeps loads out otherwise
    always_ff @(posedge psclk or posedge rst) begin
        if (rst) begin
            target <= '0;
        end else if ((state == ST_IDLE) && cmd.load) begin
            target <= cmd.new_target;
        end
    end

    // step fsm
    always_ff @(posedge psclk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd.load) begin
                        state <= ST_START;  // first compare next cycle
                    end
                end
                ST_START: begin
                    if (diff_nz) begin
                        state <= ST_WAIT_DONE;  // psen went out this cycle
                    end else begin
                        state <= ST_IDLE;       // arrived
                    end
                end
                ST_WAIT_DONE: begin
                    if (psdone_r) begin
                        state <= ST_START;      // next step or finish
                    end else if (wait_expired) begin
                        state <= ST_IDLE;       // abort the move
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // counter moves when a step is issued, backs out a step that never completed
    always_ff @(posedge psclk or posedge rst) begin
        if (rst) begin
            phase    <= '0;
            last_inc <= 1'b0;
        end else if (psen) begin
            phase    <= psincdec ? phase + 1'b1 : phase - 1'b1;
            last_inc <= psincdec;
        end else if (timeout) begin
            phase <= last_inc ? phase - 1'b1 : phase + 1'b1;  // undo unconfirmed step
        end
    end

    // done watchdog, restarts with every issued step
    always_ff @(posedge psclk or posedge rst) begin
        if (rst) begin
            wait_cnt <= '0;
        end else if (state != ST_WAIT_DONE) begin
            wait_cnt <= '0;
        end else if (!wait_expired) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

endmodule

// File: hdl/phase_status.sv
`timescale 1ns/1ps
`include "phase_macros.svh"

module phase_status
    import phase_pkg::*;
(
    input  logic                    psclk,
    input  logic                    rst,
    input  logic                    locked,     // clock manager lock
    input  logic                    busy,       // stepper not idle
    input  logic [`PHASE_WIDTH-1:0] phase,
    input  logic                    step_done,
    input  logic                    timeout,    // one cycle from the stepper
    input  logic                    rejected,   // one cycle from the decoder
    input  phase_cmd_t              cmd,
    output logic                    ready,
    output phase_status_t           status,
    output logic                    settled     // one cycle pulse
);

    logic rejected_flag;  // sticky until OP_CLEAR
    logic timeout_flag;   // sticky until OP_CLEAR

    // cmd.load covers the cycle between accept and stepper start
    assign ready = locked && !busy && !cmd.load;

    // sticky flags, a new event wins over a clear in the same cycle
    always_ff @(posedge psclk or posedge rst) begin
        if (rst) begin
            rejected_flag <= 1'b0;
            timeout_flag  <= 1'b0;
        end else begin
            rejected_flag <= (rejected_flag && !cmd.clear) || rejected;
            timeout_flag  <= (timeout_flag && !cmd.clear) || timeout;
        end
    end

    // end of a move, normal or aborted
    always_ff @(posedge psclk or posedge rst) begin
        if (rst) begin
            settled <= 1'b0;
        end else begin
            settled <= step_done || timeout;
        end
    end

    assign status = '{
        phase:        phase,
        ready:        ready,
        busy:         busy,
        cmd_rejected: rejected_flag,
        timeout:      timeout_flag
    };

endmodule

// File: hdl/phase_shift_ctrl.sv
`timescale 1ns/1ps
`include "phase_macros.svh"

module phase_shift_ctrl
    import phase_pkg::*;
(
    input  logic                    psclk,
    input  logic                    rst,        // async, active high
    input  logic                    cmd_valid,
    input  phase_op_e               cmd_op,
    input  logic [`PHASE_WIDTH-1:0] cmd_value,
    output phase_status_t           status,
    output logic                    settled,
    output logic                    psen,       // to clock manager PSEN
    output logic                    psincdec,   // to clock manager PSINCDEC
    input  logic                    psdone,     // from clock manager PSDONE
    input  logic                    locked      // from clock manager LOCKED
);

    phase_cmd_t              cmd;        // decoder to stepper and status
    logic                    ready;      // status back to decoder
    logic                    rejected;
    logic                    busy;
    logic                    step_done;
    logic                    timeout;
    logic [`PHASE_WIDTH-1:0] phase;

    phase_cmd_decoder decoder_i (
        .psclk     (psclk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_value (cmd_value),
        .ready     (ready),
        .cmd       (cmd),
        .rejected  (rejected)
    );

    phase_stepper stepper_i (
        .psclk     (psclk),
        .rst       (rst),
        .cmd       (cmd),
        .psdone    (psdone),
        .psen      (psen),
        .psincdec  (psincdec),
        .phase     (phase),
        .busy      (busy),
        .step_done (step_done),
        .timeout   (timeout)
    );

    phase_status status_i (
        .psclk     (psclk),
        .rst       (rst),
        .locked    (locked),
        .busy      (busy),
        .phase     (phase),
        .step_done (step_done),
        .timeout   (timeout),
        .rejected  (rejected),
        .cmd       (cmd),
        .ready     (ready),
        .status    (status),
        .settled   (settled)
    );

endmodule

// File: verification/ps_engine_model.sv
`timescale 1ns/1ps
`include "phase_macros.svh"

module ps_engine_model (
    input  logic psclk,
    input  logic rst,
    input  logic psen,       // step request from the controller
    input  logic hold_done,  // swallow the step in flight, no psdone
    output logic psdone,     // one cycle per finished step
    output logic locked
);

    int unsigned lock_cnt;  // cycles since reset release
    int unsigned delay;     // cycles left on the step in flight
    logic        pending;   // a step is being worked on

    // lock comes a fixed time after reset
    always_ff @(posedge psclk or posedge rst) begin
        if (rst) begin
            lock_cnt <= 0;
            locked   <= 1'b0;
        end else if (lock_cnt < `PS_LOCK_CYCLES) begin
            lock_cnt <= lock_cnt + 1;
        end else begin
            locked <= 1'b1;
        end
    end

    // psdone 3 to 12 cycles after psen
    always_ff @(posedge psclk or posedge rst) begin
        if (rst) begin
            psdone  <= 1'b0;
            pending <= 1'b0;
            delay   <= 0;
        end else begin
            psdone <= 1'b0;  // pulse by default low
            if (psen) begin
                pending <= 1'b1;
                delay   <= $urandom_range(12, 3) - 2;  // two edges are in the pipe
            end else if (pending && delay != 0) begin
                delay <= delay - 1;
            end else if (pending) begin
                pending <= 1'b0;
                psdone  <= !hold_done;  // lost step when held
            end
        end
    end

endmodule

// File: verification/phase_shift_ctrl_assertions.sv
`timescale 1ns/1ps

module phase_shift_ctrl_assertions
    import phase_pkg::*;
(
    input logic          psclk,
    input logic          rst,
    input logic          cmd_valid,
    input phase_op_e     cmd_op,
    input logic          locked,
    input logic          psen,
    input logic          psincdec,
    input logic          settled,
    input phase_status_t status
);

    int unsigned fail_count = 0;  // failed property count

    task automatic flag_failure(input string what);
        fail_count = fail_count + 1;
        $error("%s", what);
    endtask

    // one edge later the async reset has surely taken hold
    reset_quiet: assert property (@(posedge psclk) rst |=> !psen && !settled)
        else flag_failure("psen or settled high during reset");

    psen_needs_busy: assert property (@(posedge psclk) disable iff (rst)
        psen |-> status.busy)
        else flag_failure("psen high while the stepper is idle");

    psen_single: assert property (@(posedge psclk) disable iff (rst) psen |=> !psen)
        else flag_failure("psen held longer than one cycle");

    settled_single: assert property (@(posedge psclk) disable iff (rst)
        settled |=> !settled)
        else flag_failure("settled held longer than one cycle");

    no_ready_unlocked: assert property (@(posedge psclk) disable iff (rst)
        !locked |-> !status.ready)
        else flag_failure("ready high while the clock manager is unlocked");

    // moves take ready away on the next edge, clear does not
    accept_drops_ready: assert property (@(posedge psclk) disable iff (rst)
        cmd_valid && status.ready && (cmd_op != OP_CLEAR) |=> !status.ready)
        else flag_failure("ready still high after an accepted move");

    reject_sticks: assert property (@(posedge psclk) disable iff (rst)
        cmd_valid && !status.ready |=> ##1 status.cmd_rejected)
        else flag_failure("strobe while not ready did not set cmd_rejected");

    settled_idle: assert property (@(posedge psclk) disable iff (rst)
        settled |-> !status.busy)
        else flag_failure("settled pulsed while the stepper was busy");

endmodule

bind phase_shift_ctrl phase_shift_ctrl_assertions checks_i (
    .psclk     (psclk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .locked    (locked),
    .psen      (psen),
    .psincdec  (psincdec),
    .settled   (settled),
    .status    (status)
);

// File: verification/phase_shift_ctrl_tb.sv
`timescale 1ns/1ps
`include "phase_macros.svh"

module phase_shift_ctrl_tb
    import phase_pkg::*;
();

    localparam int SETTLE_LIMIT = 6000;  // 255 steps of up to 15 cycles

    logic                    psclk;
    logic                    rst;
    logic                    cmd_valid;
    phase_op_e               cmd_op;
    logic [`PHASE_WIDTH-1:0] cmd_value;
    phase_status_t           status;
    logic                    settled;
    logic                    psen;
    logic                    psincdec;
    logic                    psdone;
    logic                    locked;
    logic                    hold_done;   // engine withholds psdone

    logic [`PHASE_WIDTH-1:0] cur_phase;   // confirmed phase
    logic [`PHASE_WIDTH-1:0] cur_target;  // base of relative steps
    logic                    exp_inc;     // direction of the move under way
    int                      psen_count;
    int                      done_count;  // confirmed steps of this move

    initial psclk = 1'b0;
    always #4 psclk = ~psclk;  // 8 ns

    phase_shift_ctrl uut (
        .psclk     (psclk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_value (cmd_value),
        .status    (status),
        .settled   (settled),
        .psen      (psen),
        .psincdec  (psincdec),
        .psdone    (psdone),
        .locked    (locked)
    );

    ps_engine_model engine_i (
        .psclk     (psclk),
        .rst       (rst),
        .psen      (psen),
        .hold_done (hold_done),
        .psdone    (psdone),
        .locked    (locked)
    );

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            stop_with_failure("value mismatch");
        end
    endtask

    task automatic wait_ready(input int limit);
        int n;
        n = 0;
        do begin
            @(negedge psclk);
            n++;
        end while (!status.ready && n < limit);
        if (!status.ready) stop_with_failure("ready did not come up in time");
    endtask

    task automatic wait_settled(input int limit);
        int n;
        n = 0;
        do begin
            @(negedge psclk);
            n++;
        end while (!settled && n < limit);
        if (!settled) stop_with_failure("settled never pulsed");
    endtask

    task automatic wait_confirmed(input int steps, input int limit);
        int n;
        n = 0;
        while (done_count < steps && n < limit) begin
            @(negedge psclk);
            n++;
        end
        if (done_count < steps) stop_with_failure("engine confirmed too few steps");
    endtask

    task automatic wait_flags_clear(input int limit);
        int n;
        n = 0;
        while ((status.cmd_rejected || status.timeout) && n < limit) begin
            @(negedge psclk);
            n++;
        end
        if (status.cmd_rejected || status.timeout) stop_with_failure("sticky flags stayed set");
    endtask

    // extra_strobe keeps cmd_valid up one more cycle, landing while not ready
    task automatic issue_command(input phase_op_e op, input logic [7:0] value,
                                 input bit extra_strobe);
        @(posedge psclk);
        cmd_valid <= 1'b1;
        cmd_op    <= op;
        cmd_value <= value;
        if (extra_strobe) begin
            @(posedge psclk);
            cmd_value <= ~value;  // must not reach the target
        end
        @(posedge psclk);
        cmd_valid <= 1'b0;
    endtask

    task automatic run_move(input phase_op_e op, input logic [7:0] value,
                            input bit extra_strobe);
        logic [7:0] new_t;
        int         old_s;
        int         new_s;
        case (op)
            OP_SET_ABS:  new_t = value;
            OP_STEP_REL: new_t = cur_target + value;  // wraps in 8 bits
            OP_DEFAULT:  new_t = `PHASE_DEFAULT;
            default:     new_t = cur_target;
        endcase
        old_s   = int'($signed(cur_phase));
        new_s   = int'($signed(new_t));
        exp_inc = (new_s > old_s);
        wait_ready(200);
        psen_count = 0;
        done_count = 0;
        issue_command(op, value, extra_strobe);
        wait_settled(SETTLE_LIMIT);
        check_value("status.phase", status.phase, new_t);
        check_value("psen pulses", psen_count, exp_inc ? new_s - old_s : old_s - new_s);
        if (extra_strobe) check_value("status.cmd_rejected", status.cmd_rejected, 1);
        cur_phase  = new_t;
        cur_target = new_t;
    endtask

    // step counting and direction check, bound assertion watch
    always @(negedge psclk) begin
        if (psen) begin
            psen_count = psen_count + 1;
            check_value("psincdec", psincdec, exp_inc);
        end
        if (psdone) done_count = done_count + 1;
        if (uut.checks_i.fail_count != 0) stop_with_failure("a bound protocol assertion failed");
    end

    initial begin
        logic [7:0] to_target;
        logic [7:0] lost_phase;
        int         old_s;
        int         new_s;
        void'($urandom(32'h5c0d_4771));
        rst        = 1'b1;
        cmd_valid  = 1'b0;
        cmd_op     = OP_SET_ABS;
        cmd_value  = '0;
        hold_done  = 1'b0;
        exp_inc    = 1'b0;
        psen_count = 0;
        done_count = 0;
        cur_phase  = '0;
        cur_target = '0;
        repeat (4) @(posedge psclk);
        rst <= 1'b0;
        @(negedge psclk);
        check_value("psen", psen, 0);
        check_value("settled", settled, 0);
        check_value("status.phase", status.phase, 0);
        check_value("status.busy", status.busy, 0);
        check_value("status.ready", status.ready, 0);  // still unlocked
        wait_ready(`PS_LOCK_CYCLES + 8);
        check_value("locked", locked, 1);

        run_move(OP_SET_ABS, 8'h00, 1'b0);  // zero distance from reset
        repeat (6) run_move(OP_SET_ABS, 8'($urandom), 1'b0);
        repeat (4) run_move(OP_STEP_REL, 8'($urandom), 1'b0);
        run_move(OP_DEFAULT, 8'($urandom), 1'b0);
        run_move(OP_STEP_REL, 8'hfd, 1'b0);  // wraps below zero
        run_move(OP_SET_ABS, cur_phase, 1'b0);  // zero distance again

        // dropped strobe, then clear the flag
        run_move(OP_SET_ABS, cur_phase + 8'd7, 1'b1);
        issue_command(OP_CLEAR, 8'h00, 1'b0);
        wait_flags_clear(8);

        // two steps confirmed, then psdone withheld
        to_target = cur_phase + 8'd12;
        old_s     = int'($signed(cur_phase));
        new_s     = int'($signed(to_target));
        exp_inc   = (new_s > old_s);
        wait_ready(200);
        psen_count = 0;
        done_count = 0;
        issue_command(OP_SET_ABS, to_target, 1'b0);
        wait_confirmed(2, 200);
        @(posedge psclk);
        hold_done <= 1'b1;
        wait_settled(`PS_DONE_TIMEOUT + 40);
        lost_phase = exp_inc ? cur_phase + 8'(done_count) : cur_phase - 8'(done_count);
        check_value("status.timeout", status.timeout, 1);
        check_value("status.phase", status.phase, lost_phase);
        check_value("psen pulses", psen_count, done_count + 1);
        wait_ready(8);
        @(posedge psclk);
        hold_done <= 1'b0;
        cur_phase  = lost_phase;
        cur_target = to_target;
        issue_command(OP_CLEAR, 8'h00, 1'b0);
        wait_flags_clear(8);
        run_move(OP_DEFAULT, 8'h00, 1'b0);  // recovers from the aborted move

        repeat (4) @(negedge psclk);
        if (uut.checks_i.fail_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            stop_with_failure("a bound protocol assertion failed");
        end
    end

endmodule

// File: list.f
+incdir+hdl
hdl/phase_pkg.sv
hdl/phase_cmd_decoder.sv
hdl/phase_stepper.sv
hdl/phase_status.sv
hdl/phase_shift_ctrl.sv
verification/ps_engine_model.sv
verification/phase_shift_ctrl_assertions.sv
verification/phase_shift_ctrl_tb.sv
